//--- hw/lsu_cfg.svh
`ifndef LSU_CFG_SVH
`define LSU_CFG_SVH

// buffer geometry
`define LSU_RAM_DEPTH 256 // rows per bank, also what a zero length or gap means
`define LSU_RAM_BANKS 16

// derived widths
`define LSU_ROW_W  $clog2(`LSU_RAM_DEPTH)
`define LSU_BANK_W $clog2(`LSU_RAM_BANKS)
`define LSU_ADDR_W (`LSU_ROW_W + `LSU_BANK_W) // row bits above bank bits

`endif

//--- hw/lsu_pkg.sv
`include "lsu_cfg.svh"

package lsu_pkg;

    typedef logic [`LSU_ROW_W-1:0] row_t; // lengths and inner gap field
    typedef logic [`LSU_ADDR_W-1:0] addr_t;
    typedef logic signed [`LSU_ADDR_W:0] saddr_t; // msb is sign, dropped at the output
    typedef logic [`LSU_BANK_W:0] gap_ext_t; // bank bits plus sign of the outer gap

    // transpose cache mode, bit 2 set means the cache transposes
    typedef enum logic [2:0] {
        tc_conv16_dfifo = 3'd0,
        tc_conv16_sfifo = 3'd1,
        tc_conv32_dfifo = 3'd2,
        tc_conv32_sfifo = 3'd3,
        tc_trans_matrix = 3'd4,
        tc_trans_dwconv = 3'd7
    } tcache_mode_e;

    typedef enum logic [2:0] {
        st_idle              = 3'd0,
        st_move_fmap         = 3'd1,
        st_load_fmap         = 3'd2,
        st_load_trans_matrix = 3'd3,
        st_move_weight       = 3'd4,
        st_load_weight       = 3'd5,
        st_load_trans_dwconv = 3'd6
    } lsu_state_e;

endpackage

//--- hw/lsu_cfg_regs.sv
`timescale 1ns/1ps
`include "lsu_cfg.svh"

module lsu_cfg_regs import lsu_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 cfg_vld,
    input  logic [1:0]           cfg_type,
    input  tcache_mode_e         cfg_tcache_mode,
    input  logic                 cfg_state_clr,
    input  logic                 cfg_norm_paral,
    input  row_t                 cfg_sub_gap,
    input  gap_ext_t             cfg_sys_gap_ext,
    output tcache_mode_e         tcache_mode,
    output logic                 norm_paral_mode,
    output logic                 state_clr,
    output logic                 fifo_mode,
    output logic [`LSU_ROW_W:0]  sub_gap,
    output gap_ext_t             sys_gap_ext
);

    localparam logic [`LSU_ROW_W:0] full_gap = `LSU_RAM_DEPTH;

    logic wr_bank0;
    logic wr_bank1;

    assign wr_bank0 = cfg_vld && (cfg_type == 2'd0);
    assign wr_bank1 = cfg_vld && (cfg_type == 2'd1); // types 2 and 3 fall through

    // bank 0, clear is a one cycle strobe
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tcache_mode     <= tc_conv16_dfifo;
            norm_paral_mode <= 1'b0;
            state_clr       <= 1'b0;
        end else begin
            state_clr <= wr_bank0 && cfg_state_clr;
            if (wr_bank0) begin
                tcache_mode     <= cfg_tcache_mode;
                norm_paral_mode <= cfg_norm_paral;
            end
        end
    end

    // bank 1
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sub_gap     <= 'd1; // unit stride until configured
            sys_gap_ext <= '0;
        end else if (wr_bank1) begin
            sub_gap     <= (cfg_sub_gap == '0) ? full_gap : {1'b0, cfg_sub_gap};
            sys_gap_ext <= cfg_sys_gap_ext;
        end
    end

    assign fifo_mode = (tcache_mode == tc_conv16_sfifo) || (tcache_mode == tc_conv32_sfifo);

    // the clear strobe must not look like a level to the consumers
    a_clr_one_shot: assert property (
        @(posedge clk) disable iff (!rst_n) state_clr |=> !state_clr
    );

endmodule

//--- hw/lsu_cmd_fsm.sv
`timescale 1ns/1ps

module lsu_cmd_fsm import lsu_pkg::*; (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         req,
    input  logic         we,
    input  logic         weight_mode,
    input  logic         mv_last_dis,
    input  addr_t        start_addr,
    input  row_t         sub_len,
    input  row_t         sys_len,
    input  row_t         sys_gap,
    input  tcache_mode_e tcache_mode,
    input  logic         norm_paral_mode,
    input  logic         data_ok,
    output logic         grant,
    output lsu_state_e   state,
    output logic         norm_mode,
    output logic         weight_rd_mode,
    output logic         norm_parallel,
    output logic         fmap_last,
    output addr_t        cmd_addr,
    output row_t         cmd_sub_len,
    output row_t         cmd_sys_len,
    output row_t         cmd_sys_gap
);

    lsu_state_e next_state;
    logic       mv_last_dis_q;

    // {weight_mode, tcache bit 2, we} selects the access mode
    function automatic lsu_state_e decode_mode(logic wmode, logic tc_trans, logic wr);
        lsu_state_e st;
        casez ({wmode, tc_trans, wr})
            3'b000:  st = st_move_fmap;
            3'b001:  st = st_load_fmap;
            3'b011:  st = st_load_trans_matrix;
            3'b1?0:  st = st_move_weight; // weight read never uses the cache
            3'b101:  st = st_load_weight;
            3'b111:  st = st_load_trans_dwconv;
            default: st = st_idle; // fmap read under transpose has no mode
        endcase
        return st;
    endfunction

    assign grant = req; // always accepted

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            norm_mode     <= 1'b0;
            mv_last_dis_q <= 1'b0;
        end else if (req) begin
            norm_mode     <= weight_mode;
            mv_last_dis_q <= mv_last_dis;
        end
    end

    // command payload
    always_ff @(posedge clk) begin
        if (req) begin
            cmd_addr    <= start_addr;
            cmd_sub_len <= sub_len;
            cmd_sys_len <= sys_len;
            cmd_sys_gap <= sys_gap;
        end
    end

    always_comb begin
        next_state = state;
        if ((state == st_idle) || data_ok) begin
            next_state = req ? decode_mode(weight_mode, tcache_mode[2], we) : st_idle;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state          <= st_idle;
            weight_rd_mode <= 1'b0;
        end else begin
            state          <= next_state;
            weight_rd_mode <= (state == st_move_weight);
        end
    end

    assign norm_parallel = (state == st_move_weight) || norm_paral_mode;
    assign fmap_last     = (state == st_move_fmap) && !mv_last_dis_q && data_ok;

    // a new command may only be issued when idle or on the completion beat
    a_req_when_free: assert property (
        @(posedge clk) disable iff (!rst_n) ((state != st_idle) && !data_ok) |-> !req
    );

endmodule

//--- hw/lsu_addr_gen.sv
`timescale 1ns/1ps
`include "lsu_cfg.svh"

module lsu_addr_gen import lsu_pkg::*; (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                req,
    input  addr_t               start_addr,
    input  lsu_state_e          state,
    input  addr_t               cmd_addr,
    input  row_t                cmd_sub_len,
    input  row_t                cmd_sys_len,
    input  row_t                cmd_sys_gap,
    input  logic [`LSU_ROW_W:0] sub_gap,
    input  gap_ext_t            sys_gap_ext,
    input  logic                fifo_mode,
    input  logic                load_vld,
    input  logic                move_fmap_en,
    output addr_t               addr,
    output logic                addr_valid,
    output logic                wr_en,
    output logic                data_ok
);

    saddr_t work_addr;
    row_t   sub_cnt;
    row_t   sys_cnt;
    row_t   sub_last;
    row_t   sys_last;
    logic   sub_end;
    logic   sys_end;
    logic   is_load;
    logic   beat;
    logic   odd_round;
    saddr_t sub_stride;
    saddr_t sys_stride;
    saddr_t sys_gap_raw;
    saddr_t step;

    // a zero length wraps to 255 here, so it counts 256 beats
    assign sub_last = cmd_sub_len - 1'b1;
    assign sys_last = cmd_sys_len - 1'b1;
    assign sub_end  = (sub_cnt == sub_last);
    assign sys_end  = (sys_cnt == sys_last);

    assign is_load = (state == st_load_fmap) || (state == st_load_trans_matrix) ||
                     (state == st_load_weight) || (state == st_load_trans_dwconv);

    always_comb begin
        case (state)
            st_move_weight: beat = 1'b1; // weight read streams every cycle
            st_move_fmap:   beat = move_fmap_en;
            st_load_fmap,
            st_load_trans_matrix,
            st_load_weight,
            st_load_trans_dwconv: beat = load_vld;
            default:        beat = 1'b0;
        endcase
    end

    // sub_gap already carries the zero expansion
    assign sub_stride  = {{(`LSU_ADDR_W - `LSU_ROW_W){1'b0}}, sub_gap};
    assign sys_gap_raw = {sys_gap_ext, cmd_sys_gap}; // signed 13 bit outer stride
    assign sys_stride  = (sys_gap_raw == '0) ? saddr_t'(`LSU_RAM_DEPTH) : sys_gap_raw;

    // dual fifo fmap reads need even steps
    assign odd_round = (state == st_move_fmap) && !fifo_mode;

    always_comb begin
        step = sub_end ? sys_stride : sub_stride;
        if (odd_round && step[0]) begin
            step = step + saddr_t'(1);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            work_addr <= '0;
            sub_cnt   <= '0;
            sys_cnt   <= '0;
        end else if (req) begin
            work_addr <= saddr_t'({1'b0, start_addr}); // first beat uses the start address
            sub_cnt   <= '0;
            sys_cnt   <= '0;
        end else if (beat) begin
            if (!sub_end) begin
                sub_cnt   <= sub_cnt + 1'b1;
                work_addr <= work_addr + step;
            end else if (!sys_end) begin
                sub_cnt   <= '0;
                sys_cnt   <= sys_cnt + 1'b1;
                work_addr <= work_addr + step;
            end else begin
                // pattern done, park on the command base
                sub_cnt   <= '0;
                sys_cnt   <= '0;
                work_addr <= saddr_t'({1'b0, cmd_addr});
            end
        end
    end

    assign addr       = work_addr[`LSU_ADDR_W-1:0]; // sign bit dropped, wraps at 12 bits
    assign addr_valid = beat;
    assign wr_en      = is_load; // held for the whole load, beat or not
    assign data_ok    = beat && sub_end && sys_end;

    // buffer strobes only while a command runs and its counters stay inside the pattern
    a_no_strobe_idle: assert property (
        @(posedge clk) disable iff (!rst_n) (wr_en || addr_valid) |->
            ((state != st_idle) && (sub_cnt <= sub_last) && (sys_cnt <= sys_last))
    );

endmodule

//--- hw/lsu_top.sv
`timescale 1ns/1ps
`include "lsu_cfg.svh"

module lsu_top import lsu_pkg::*; (
    input  logic         clk,
    input  logic         rst_n,
    // command
    input  logic         req,
    output logic         grant,
    input  logic         we,
    input  logic         weight_mode,
    input  logic         mv_last_dis,
    input  addr_t        start_addr,
    input  row_t         sub_len,
    input  row_t         sys_len,
    input  row_t         sys_gap,
    output logic         data_ok,
    // configuration
    input  logic         cfg_vld,
    input  logic [1:0]   cfg_type,
    input  tcache_mode_e cfg_tcache_mode,
    input  logic         cfg_state_clr,
    input  logic         cfg_norm_paral,
    input  row_t         cfg_sub_gap,
    input  gap_ext_t     cfg_sys_gap_ext,
    // beat enables
    input  logic         load_vld,     // from the network
    input  logic         move_fmap_en, // from the transpose cache
    // buffer side
    output addr_t        addr,
    output logic         addr_valid,
    output logic         wr_en,
    // status and mode
    output tcache_mode_e tcache_mode,
    output logic         state_clr,
    output logic         fifo_mode,
    output logic         norm_mode,
    output logic         weight_rd_mode,
    output logic         norm_parallel,
    output logic         fmap_last
);

    logic                norm_paral_mode;
    logic [`LSU_ROW_W:0] sub_gap;
    gap_ext_t            sys_gap_ext;
    lsu_state_e          state;
    addr_t               cmd_addr;
    row_t                cmd_sub_len;
    row_t                cmd_sys_len;
    row_t                cmd_sys_gap;

    lsu_cfg_regs u_cfg_regs (.clk, .rst_n, .cfg_vld, .cfg_type, .cfg_tcache_mode, .cfg_state_clr,
        .cfg_norm_paral, .cfg_sub_gap, .cfg_sys_gap_ext, .tcache_mode, .norm_paral_mode,
        .state_clr, .fifo_mode, .sub_gap, .sys_gap_ext);

    lsu_cmd_fsm u_cmd_fsm (.clk, .rst_n, .req, .we, .weight_mode, .mv_last_dis, .start_addr,
        .sub_len, .sys_len, .sys_gap, .tcache_mode, .norm_paral_mode, .data_ok, .grant, .state,
        .norm_mode, .weight_rd_mode, .norm_parallel, .fmap_last, .cmd_addr, .cmd_sub_len,
        .cmd_sys_len, .cmd_sys_gap);

    lsu_addr_gen u_addr_gen (.clk, .rst_n, .req, .start_addr, .state, .cmd_addr, .cmd_sub_len,
        .cmd_sys_len, .cmd_sys_gap, .sub_gap, .sys_gap_ext, .fifo_mode, .load_vld,
        .move_fmap_en, .addr, .addr_valid, .wr_en, .data_ok);

endmodule

//--- test/tb_lsu.sv
`timescale 1ns/1ps
`include "lsu_cfg.svh"

module tb_lsu import lsu_pkg::*; ();

    logic         clk;
    logic         rst_n;
    logic         req, grant, we, weight_mode, mv_last_dis, data_ok;
    addr_t        start_addr;
    row_t         sub_len, sys_len, sys_gap;
    logic         cfg_vld, cfg_state_clr, cfg_norm_paral;
    logic [1:0]   cfg_type;
    tcache_mode_e cfg_tcache_mode;
    row_t         cfg_sub_gap;
    gap_ext_t     cfg_sys_gap_ext;
    logic         load_vld, move_fmap_en;
    addr_t        addr;
    logic         addr_valid, wr_en, state_clr, fifo_mode, norm_mode;
    logic         weight_rd_mode, norm_parallel, fmap_last;
    tcache_mode_e tcache_mode;

    // reference model
    lsu_state_e   exp_state;
    lsu_state_e   pend_mode; // mode the next request should decode to
    addr_t        m_addr, m_base;
    row_t         m_gap;
    int           m_sub, m_sys, m_sub_n, m_sys_n;
    logic         m_mvdis, exp_valid, exp_last, exp_done, exp_clr, exp_fifo;
    logic         exp_wrd, exp_norm;
    tcache_mode_e sh_tc;
    logic         sh_norm;
    row_t         sh_sub_gap;
    gap_ext_t     sh_ext;

    int           mismatches = 0;
    int           timeouts = 0;
    logic [31:0]  lfsr = 32'h0bd920ec;

    lsu_top u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // fibonacci lfsr, taps 32 22 2 1
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_bit()};
        end
        return v;
    endfunction

    function automatic int full_len(input row_t n);
        return (n == '0) ? `LSU_RAM_DEPTH : int'(n);
    endfunction

    // inner gap or signed outer stride, odd steps rounded up in dual fifo fmap moves
    function automatic int step_of(input logic outer);
        int s;
        if (outer) begin
            s = int'($signed({sh_ext, m_gap}));
            s = (s == 0) ? `LSU_RAM_DEPTH : s;
        end else begin
            s = full_len(sh_sub_gap);
        end
        if ((exp_state == st_move_fmap) && !exp_fifo && s[0]) begin
            s = s + 1;
        end
        return s;
    endfunction

    task automatic flag_mismatch(input string name, input int expv, input int gotv);
        mismatches++;
        $display("[ERROR] %0t ns %s expected %0h actual %0h", $time, name, expv, gotv);
    endtask

    assign exp_fifo = (sh_tc == tc_conv16_sfifo) || (sh_tc == tc_conv32_sfifo);
    assign exp_last = (m_sub == m_sub_n - 1) && (m_sys == m_sys_n - 1);
    assign exp_done = exp_valid && exp_last;

    always_comb begin
        case (exp_state)
            st_idle:        exp_valid = 1'b0;
            st_move_weight: exp_valid = 1'b1;
            st_move_fmap:   exp_valid = move_fmap_en;
            default:        exp_valid = load_vld; // all four load modes
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            exp_state  <= st_idle;
            exp_clr    <= 1'b0;
            exp_wrd    <= 1'b0;
            exp_norm   <= 1'b0;
            sh_tc      <= tc_conv16_dfifo;
            sh_norm    <= 1'b0;
            sh_sub_gap <= 8'd1;
            sh_ext     <= '0;
        end else begin
            exp_clr <= cfg_vld && (cfg_type == 2'd0) && cfg_state_clr;
            exp_wrd <= (exp_state == st_move_weight);
            if (cfg_vld && (cfg_type == 2'd0)) begin
                sh_tc   <= cfg_tcache_mode;
                sh_norm <= cfg_norm_paral;
            end
            if (cfg_vld && (cfg_type == 2'd1)) begin
                sh_sub_gap <= cfg_sub_gap;
                sh_ext     <= cfg_sys_gap_ext;
            end
            if (req) begin
                exp_state <= pend_mode;
                exp_norm  <= weight_mode;
                m_addr    <= start_addr;
                m_base    <= start_addr;
                m_gap     <= sys_gap;
                m_sub     <= 0;
                m_sys     <= 0;
                m_sub_n   <= full_len(sub_len);
                m_sys_n   <= full_len(sys_len);
                m_mvdis   <= mv_last_dis;
            end else if (exp_valid) begin
                if (m_sub != m_sub_n - 1) begin
                    m_sub  <= m_sub + 1;
                    m_addr <= m_addr + addr_t'(step_of(1'b0));
                end else if (m_sys != m_sys_n - 1) begin
                    m_sub  <= 0;
                    m_sys  <= m_sys + 1;
                    m_addr <= m_addr + addr_t'(step_of(1'b1));
                end else begin
                    exp_state <= st_idle;
                    m_addr    <= m_base;
                end
            end
        end
    end

    a_state: assert property (@(posedge clk) disable iff (!rst_n) u_dut.state == exp_state)
        else flag_mismatch("state", $sampled(exp_state), $sampled(u_dut.state));
    a_addr: assert property (@(posedge clk) disable iff (!rst_n) addr_valid |-> addr == m_addr)
        else flag_mismatch("addr", $sampled(m_addr), $sampled(addr));
    a_valid: assert property (@(posedge clk) disable iff (!rst_n) addr_valid == exp_valid)
        else flag_mismatch("addr_valid", $sampled(exp_valid), $sampled(addr_valid));
    a_wr: assert property (@(posedge clk) disable iff (!rst_n)
        wr_en == !(exp_state inside {st_idle, st_move_fmap, st_move_weight}))
        else flag_mismatch("wr_en", !$sampled(wr_en), $sampled(wr_en));
    a_done: assert property (@(posedge clk) disable iff (!rst_n) data_ok == exp_done)
        else flag_mismatch("data_ok", $sampled(exp_done), $sampled(data_ok));
    a_last: assert property (@(posedge clk) disable iff (!rst_n)
        fmap_last == (exp_done && (exp_state == st_move_fmap) && !m_mvdis))
        else flag_mismatch("fmap_last", !$sampled(fmap_last), $sampled(fmap_last));
    a_clr: assert property (@(posedge clk) disable iff (!rst_n) state_clr == exp_clr)
        else flag_mismatch("state_clr", $sampled(exp_clr), $sampled(state_clr));
    a_fifo: assert property (@(posedge clk) disable iff (!rst_n) fifo_mode == exp_fifo)
        else flag_mismatch("fifo_mode", $sampled(exp_fifo), $sampled(fifo_mode));
    a_npar: assert property (@(posedge clk) disable iff (!rst_n)
        norm_parallel == ((exp_state == st_move_weight) || sh_norm))
        else flag_mismatch("norm_parallel", !$sampled(norm_parallel), $sampled(norm_parallel));
    a_wrd: assert property (@(posedge clk) disable iff (!rst_n) weight_rd_mode == exp_wrd)
        else flag_mismatch("weight_rd_mode", $sampled(exp_wrd), $sampled(weight_rd_mode));
    a_norm: assert property (@(posedge clk) disable iff (!rst_n) norm_mode == exp_norm)
        else flag_mismatch("norm_mode", $sampled(exp_norm), $sampled(norm_mode));
    a_grant: assert property (@(posedge clk) disable iff (!rst_n) grant == req)
        else flag_mismatch("grant", $sampled(req), $sampled(grant));
    a_tc: assert property (@(posedge clk) disable iff (!rst_n) tcache_mode == sh_tc)
        else flag_mismatch("tcache_mode", $sampled(sh_tc), $sampled(tcache_mode));

    task automatic finish_test();
        $display("closing: %0d mismatch errors, %0d timeout errors", mismatches, timeouts);
        if ((mismatches == 0) && (timeouts == 0)) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    endtask

    task automatic write_cfg(input logic [1:0] typ, input tcache_mode_e tc, input logic clr,
                             input logic norm, input row_t sg, input gap_ext_t ext);
        {cfg_type, cfg_tcache_mode, cfg_state_clr, cfg_norm_paral} = {typ, tc, clr, norm};
        {cfg_sub_gap, cfg_sys_gap_ext} = {sg, ext};
        cfg_vld = 1'b1;
        @(posedge clk);
        #5;
        cfg_vld = 1'b0;
    endtask

    task automatic start_cmd(input lsu_state_e mode, input logic wr, input logic wmode,
                             input logic mdis, input addr_t a, input row_t sl, input row_t yl,
                             input row_t g);
        pend_mode = mode;
        {we, weight_mode, mv_last_dis, start_addr} = {wr, wmode, mdis, a};
        {sub_len, sys_len, sys_gap} = {sl, yl, g};
        req = 1'b1;
        @(posedge clk);
        #5;
        req = 1'b0;
    endtask

    // random beat enables each cycle until data_ok shows up
    task automatic wait_done(input int max_cycles);
        int   n;
        logic seen;
        n = 0;
        seen = 1'b0;
        while (!seen && (n < max_cycles)) begin
            load_vld     = lfsr_bit();
            move_fmap_en = lfsr_bit();
            #40;
            seen = data_ok;
            @(posedge clk);
            #5;
            n++;
        end
        {load_vld, move_fmap_en} = 2'b00;
        if (!seen) begin
            timeouts++;
            $display("timeout, no data_ok within %0d cycles at %0t ns", max_cycles, $time);
            finish_test();
        end
    endtask

    initial begin
        {req, we, weight_mode, mv_last_dis, cfg_vld, cfg_state_clr, cfg_norm_paral} = '0;
        {start_addr, sub_len, sys_len, sys_gap, cfg_type, cfg_sub_gap, cfg_sys_gap_ext} = '0;
        {load_vld, move_fmap_en} = 2'b00;
        cfg_tcache_mode = tc_conv16_dfifo;
        pend_mode       = st_idle;
        rst_n           = 1'b0;
        repeat (4) @(posedge clk);
        #5;
        rst_n = 1'b1;
        if ({state_clr, addr_valid, wr_en, data_ok, fmap_last, weight_rd_mode, norm_mode} != '0)
        begin
            mismatches++;
            $display("control outputs not all low after reset at %0t ns", $time);
        end

        // weight move, 3 x 2 beats with positive gaps
        write_cfg(2'd1, tc_conv16_dfifo, 1'b0, 1'b0, 8'd3, 5'h00);
        start_cmd(st_move_weight, 1'b0, 1'b1, 1'b0, 12'h100, 8'd3, 8'd2, 8'h20);
        wait_done(20);

        // fmap load paced by the network
        write_cfg(2'd1, tc_conv16_dfifo, 1'b0, 1'b0, row_t'(rand_bits(8)), 5'h00);
        start_cmd(st_load_fmap, 1'b1, 1'b0, 1'b0, addr_t'(rand_bits(12)), 8'd4, 8'd3,
                  row_t'(rand_bits(8)));
        wait_done(200);

        // fmap moves with odd gaps: dual fifo, last pulse masked, then single fifo
        write_cfg(2'd0, tc_conv32_dfifo, 1'b0, 1'b0, 8'd0, 5'h00);
        write_cfg(2'd1, tc_conv32_dfifo, 1'b0, 1'b0, row_t'(rand_bits(8)) | 8'd1, 5'h00);
        for (int i = 0; i < 3; i++) begin
            if (i == 2) begin
                write_cfg(2'd0, tc_conv16_sfifo, 1'b0, 1'b0, 8'd0, 5'h00);
            end
            start_cmd(st_move_fmap, 1'b0, 1'b0, (i == 1), addr_t'(rand_bits(12)), 8'd3, 8'd3,
                      row_t'(rand_bits(8)) | 8'd1);
            wait_done(200);
        end

        // zero inner gap is 256, outer stride {1f, f0} is -16 and wraps below zero
        write_cfg(2'd1, tc_conv16_dfifo, 1'b0, 1'b0, 8'd0, 5'h1f);
        write_cfg(2'd0, tc_conv16_dfifo, 1'b1, 1'b0, 8'd0, 5'h00);
        write_cfg(2'd2, tc_trans_dwconv, 1'b1, 1'b1, 8'd5, 5'h00); // must be ignored
        start_cmd(st_move_weight, 1'b0, 1'b1, 1'b0, 12'hf10, 8'd4, 8'd3, 8'hf0);
        wait_done(30);
        start_cmd(st_move_weight, 1'b0, 1'b1, 1'b0, 12'h005, 8'd0, 8'd1, 8'h01);
        wait_done(300);

        // transpose cache loads
        write_cfg(2'd0, tc_trans_matrix, 1'b0, 1'b1, 8'd0, 5'h00);
        write_cfg(2'd1, tc_trans_matrix, 1'b0, 1'b0, 8'd2, 5'h00);
        start_cmd(st_load_trans_matrix, 1'b1, 1'b0, 1'b0, 12'h040, 8'd3, 8'd2, 8'h10);
        wait_done(100);
        start_cmd(st_load_trans_dwconv, 1'b1, 1'b1, 1'b0, 12'h080, 8'd2, 8'd3, 8'h08);
        wait_done(100);

        // chained request lands in the data_ok cycle of a 4 beat weight move
        start_cmd(st_move_weight, 1'b0, 1'b1, 1'b0, 12'h200, 8'd2, 8'd2, 8'h04);
        repeat (3) begin
            @(posedge clk);
            #5;
        end
        start_cmd(st_move_weight, 1'b0, 1'b1, 1'b0, 12'h300, 8'd2, 8'd1, 8'h04);
        wait_done(20);
        finish_test();
    end

endmodule

//--- verilog.f
+incdir+hw
hw/lsu_pkg.sv
hw/lsu_cfg_regs.sv
hw/lsu_cmd_fsm.sv
hw/lsu_addr_gen.sv
hw/lsu_top.sv
test/tb_lsu.sv

//--- run_sim.sh
#!/bin/sh
# build with Verilator, run, and look for the fail message in the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_lsu -f verilog.f -o tb_lsu \
    > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/tb_lsu > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log
grep -qF '*** TEST FAILED ***' sim.log && exit 1 || exit 0
